/* dv/tb_rv_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_exec;

  localparam int n_loads     = 8;
  localparam int n_random    = 200;
  localparam int txn_count   = 4 + 3 * n_loads + 3 + 16 + 10 * 6 + 9 * 5 + 18 + 32 + 5 + n_random;
  localparam int cycle_limit = 20 * txn_count + 100;

  localparam logic [2:0] op_f3   [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
  localparam logic       op_alt  [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
  localparam logic [2:0] imm_f3  [9]  = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
  localparam logic [2:0] br_f3   [6]  = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
  localparam logic [4:0] pair_a  [6]  = '{5'd1, 5'd2, 5'd1, 5'd2, 5'd6, 5'd0};
  localparam logic [4:0] pair_b  [6]  = '{5'd2, 5'd1, 5'd3, 5'd4, 5'd7, 5'd0};

  logic        clk;
  logic        reset;
  logic        req;
  logic [31:0] instr;
  logic [31:0] pc;
  logic        ack;
  logic [31:0] result;
  logic        branch_taken;

  logic [31:0] model_regs [32];
  logic [31:0] rng_state;
  logic [31:0] exp_res_q [$];
  logic        exp_tk_q [$];
  logic        ack_prev;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;

  rv_exec_top u_dut (
    .clk          (clk),
    .reset        (reset),
    .req          (req),
    .ack          (ack),
    .instr        (instr),
    .pc           (pc),
    .result       (result),
    .branch_taken (branch_taken)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Encoders ------------
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  // Reference model -----
  function automatic void ref_model(input logic [31:0] ins, input logic [31:0] pc_v,
                                    input logic [31:0] regs [32], output logic [31:0] res,
                                    output logic taken, output logic we);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_b;
    logic [2:0]  f3;
    a     = regs[ins[19:15]];
    b     = regs[ins[24:20]];
    imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    f3    = ins[14:12];
    taken = 1'b0;
    we    = 1'b1;
    res   = a + b;
    case (ins[6:0])
      7'b0110011, 7'b0010011: begin
        if (!ins[5]) begin
          b = {{20{ins[31]}}, ins[31:20]};  // OP-IMM takes the I immediate
        end
        case (f3)
          3'b000:  res = (ins[5] && ins[30]) ? a - b : a + b;
          3'b001:  res = a << b[4:0];
          3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          3'b011:  res = (a < b) ? 32'd1 : 32'd0;
          3'b100:  res = a ^ b;
          3'b101: begin
            if (ins[30]) begin
              res = $signed(a) >>> b[4:0];
            end else begin
              res = a >> b[4:0];
            end
          end
          3'b110:  res = a | b;
          default: res = a & b;
        endcase
      end
      7'b0110111: res = {ins[31:12], 12'b0};
      7'b0010111: res = pc_v + {ins[31:12], 12'b0};
      7'b1100011: begin
        we  = 1'b0;
        res = pc_v + imm_b;
        case (f3)
          3'b001:  taken = (a != b);
          3'b100:  taken = $signed(a) < $signed(b);
          3'b101:  taken = $signed(a) >= $signed(b);
          3'b110:  taken = a < b;
          3'b111:  taken = a >= b;
          default: taken = (a == b);
        endcase
      end
      default: we = 1'b0;
    endcase
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] expected, input string what);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("ERR %0t ns: %s got %08h, expected %08h", $time, what, got, expected);
    end
  endtask

  // Drives one instruction through the full four-phase handshake
  task automatic run_instr(input logic [31:0] ins, input int hold);
    logic [31:0] res;
    logic [31:0] pc_v;
    logic        taken;
    logic        we;
    int          n;
    pc_v = next_rand() & 32'hFFFF_FFFC;
    ref_model(ins, pc_v, model_regs, res, taken, we);
    exp_res_q.push_back(res);
    exp_tk_q.push_back(taken);
    @(posedge clk);
    instr <= ins;
    pc    <= pc_v;
    req   <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!ack);
    check(n, 2, "cycles from req to ack");
    repeat (hold) begin
      @(negedge clk);
      check({31'b0, ack}, 32'd1, "ack while req held");
    end
    @(posedge clk);
    req <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (ack);
    check(n, 2, "cycles from req low to ack low");
    if (we && ins[11:7] != 5'd0) begin
      model_regs[ins[11:7]] = res;
    end
  endtask

  task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
    logic [19:0] hi;
    hi = value[31:12] + 20'(value[11]);  // ADDI sign-extends the low half
    run_instr(enc_u(hi, rd, 7'b0110111), 0);
    run_instr(enc_i(value[11:0], rd, 3'b000, rd), 0);
  endtask

  task automatic read_back(input logic [4:0] rs);
    run_instr(enc_r(7'h00, 5'd0, rs, 3'b000, 5'd0), 0);
  endtask

  function automatic logic [31:0] random_instr();
    logic [31:0] v;
    logic [31:0] w;
    logic [2:0]  f3;
    v  = next_rand();
    w  = next_rand();
    f3 = w[14:12];
    case (v[2:0])
      3'd0, 3'd1: begin
        return enc_r((v[3] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                     w[24:20], w[19:15], f3, w[11:7]);
      end
      3'd2, 3'd3: begin
        if (f3 == 3'd1 || f3 == 3'd5) begin
          return enc_i({1'b0, v[3] && f3 == 3'd5, 5'b0, w[24:20]}, w[19:15], f3, w[11:7]);
        end
        return enc_i(w[31:20], w[19:15], f3, w[11:7]);
      end
      3'd4: return enc_u(w[31:12], w[11:7], 7'b0110111);
      3'd5: return enc_u(w[31:12], w[11:7], 7'b0010111);
      default: begin
        if (f3[2:1] == 2'b01) begin
          f3[2] = 1'b1;  // Skip the two reserved branch codes
        end
        return enc_b({v[15:4], 1'b0}, w[24:20], w[19:15], f3);
      end
    endcase
  endfunction

  // Compares each result once, on the rise of ack
  always @(negedge clk) begin
    if (reset) begin
      ack_prev = 1'b0;
    end else begin
      if (ack && !ack_prev) begin
        if (exp_res_q.size() == 0) begin
          errors++;
          $display("ack rose at %0t ns with no request outstanding", $time);
        end else begin
          check(result, exp_res_q.pop_front(), "result");
          check({31'b0, branch_taken}, {31'b0, exp_tk_q.pop_front()}, "branch_taken");
        end
      end
      ack_prev = ack;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    logic [31:0] v;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [11:0] imm;
    clk       = 1'b0;
    reset     = 1'b1;
    req       = 1'b0;
    instr     = '0;
    pc        = '0;
    rng_state = 32'd60;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check({31'b0, ack}, 32'd0, "ack after reset");
    check(result, 32'd0, "result after reset");

    // Handshake and loads -
    run_instr(enc_i(12'd1, 5'd5, 3'b000, 5'd5), 4);  // Held req must not write twice
    read_back(5'd5);
    run_instr(enc_i(12'd1, 5'd5, 3'b000, 5'd5), 7);
    read_back(5'd5);
    for (int i = 0; i < n_loads; i++) begin
      v  = next_rand();
      ra = (v[4:0] == 5'd0) ? 5'd1 : v[4:0];
      v  = next_rand();
      load_reg(ra, v);
      read_back(ra);
      check(result, v, "read-back of loaded value");
    end
    load_reg(5'd0, 32'hDEAD_BEEF);
    read_back(5'd0);
    load_reg(5'd1, 32'h8000_0000);
    load_reg(5'd2, 32'hFFFF_FFFF);
    load_reg(5'd3, 32'd31);
    load_reg(5'd4, 32'd0);
    for (int i = 6; i < 10; i++) begin
      load_reg(5'(i), next_rand());
    end

    // OP and OP-IMM -------
    for (int k = 0; k < 10; k++) begin
      for (int j = 0; j < 6; j++) begin
        v  = next_rand();
        ra = (j == 5) ? v[12:8] : pair_a[j];
        rb = (j == 5) ? v[20:16] : pair_b[j];
        run_instr(enc_r(op_alt[k] ? 7'h20 : 7'h00, rb, ra, op_f3[k],
                        5'd10 + 5'(v[7:0] % 8'd22)), 0);
      end
    end
    for (int k = 0; k < 9; k++) begin
      for (int j = 0; j < 5; j++) begin
        v   = next_rand();
        ra  = (j == 0) ? 5'd1 : (j == 1) ? 5'd2 : v[12:8];
        imm = (j == 0) ? 12'hFFF : (j == 1) ? 12'h800 : v[31:20];
        if (imm_f3[k] == 3'd1 || imm_f3[k] == 3'd5) begin
          imm = {1'b0, k == 8, 5'b0, (j == 0) ? 5'd0 : (j == 1) ? 5'd31 : v[24:20]};
        end
        run_instr(enc_i(imm, ra, imm_f3[k], 5'd10 + 5'(v[7:0] % 8'd22)), 0);
      end
    end

    // Branches ------------
    for (int k = 0; k < 6; k++) begin
      for (int j = 0; j < 3; j++) begin
        v  = next_rand();
        ra = (j == 0) ? 5'd2 : (j == 1) ? 5'd1 : 5'd4;  // Equal, signed less, unsigned less
        rb = (j == 1) ? 5'd4 : 5'd2;
        run_instr(enc_b({v[12:1], 1'b0}, rb, ra, br_f3[k]), 0);
      end
    end
    for (int i = 0; i < 32; i++) begin
      read_back(5'(i));
    end

    for (int i = 0; i < 5; i++) begin
      v = next_rand();
      run_instr(enc_u(v[31:12], 5'd10 + 5'(v[7:0] % 8'd22), 7'b0010111), 0);
    end
    repeat (n_random) run_instr(random_instr(), 0);

    @(negedge clk);
    if (exp_res_q.size() != 0) begin
      errors++;
      $display("%0d results were never acknowledged", exp_res_q.size());
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
rtl/rv_exec_pkg.sv
rtl/alu_req_if.sv
rtl/rv_decoder.sv
rtl/rv_alu.sv
rtl/rv_regfile.sv
rtl/rv_exec_ctrl.sv
rtl/rv_exec_top.sv
dv/tb_rv_exec.sv

/* rtl/alu_req_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface alu_req_if;

  rv_exec_pkg::alu_op_e          alu_op;
  logic                          double_cal;  // Branch: src1/src2 give target, src3/src4 compare
  logic [rv_exec_pkg::xlen-1:0]  src1;
  logic [rv_exec_pkg::xlen-1:0]  src2;
  logic [rv_exec_pkg::xlen-1:0]  src3;
  logic [rv_exec_pkg::xlen-1:0]  src4;

  modport decoder (
    output alu_op,
    output double_cal,
    output src1,
    output src2,
    output src3,
    output src4
  );

  modport alu (
    input alu_op,
    input double_cal,
    input src1,
    input src2,
    input src3,
    input src4
  );

  modport ctrl (
    input double_cal
  );

endinterface

`default_nettype wire

/* rtl/rv_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
  alu_req_if.alu                      alu,
  output logic [rv_exec_pkg::xlen-1:0] alu_result1,
  output logic [rv_exec_pkg::xlen-1:0] alu_result2
);

  logic                           use_sub;
  logic [rv_exec_pkg::xlen-1:0]   adder_b;
  logic [rv_exec_pkg::xlen-1:0]   adder_sum;
  logic                           adder_cout;
  logic [rv_exec_pkg::xlen-1:0]   cmp_sum;
  logic                           cmp_cout;
  logic                           slt_bit;
  logic                           sltu_bit;
  logic                           lt_bit;
  logic                           ltu_bit;
  logic                           eq_bit;
  logic [rv_exec_pkg::xlen-1:0]   sll_value;
  logic [2*rv_exec_pkg::xlen-1:0] sr64_value;
  logic                           sra_fill;

  // Main adder ----------
  assign use_sub = (alu.alu_op == rv_exec_pkg::alu_sub)
                 | (alu.alu_op == rv_exec_pkg::alu_slt)
                 | (alu.alu_op == rv_exec_pkg::alu_sltu);
  assign adder_b = use_sub ? ~alu.src2 : alu.src2;
  assign {adder_cout, adder_sum} = {1'b0, alu.src1} + {1'b0, adder_b}
                                 + {{rv_exec_pkg::xlen{1'b0}}, use_sub};

  assign slt_bit  = (alu.src1[31] & ~alu.src2[31])
                  | ((alu.src1[31] ~^ alu.src2[31]) & adder_sum[31]);
  assign sltu_bit = ~adder_cout;  // No carry out of a - b means a < b

  // Compare adder, always subtracting src4 from src3
  assign {cmp_cout, cmp_sum} = {1'b0, alu.src3} + {1'b0, ~alu.src4}
                             + {{rv_exec_pkg::xlen{1'b0}}, 1'b1};

  assign lt_bit  = (alu.src3[31] & ~alu.src4[31])
                 | ((alu.src3[31] ~^ alu.src4[31]) & cmp_sum[31]);
  assign ltu_bit = ~cmp_cout;
  assign eq_bit  = (alu.src3 == alu.src4);

  // Shifter -------------
  assign sra_fill   = (alu.alu_op == rv_exec_pkg::alu_sra) & alu.src1[31];
  assign sll_value  = alu.src1 << alu.src2[4:0];
  assign sr64_value = {{rv_exec_pkg::xlen{sra_fill}}, alu.src1} >> alu.src2[4:0];

  always_comb begin
    if (alu.double_cal) begin
      alu_result1 = adder_sum;  // Branch target
    end else begin
      case (alu.alu_op)
        rv_exec_pkg::alu_slt:  alu_result1 = {{(rv_exec_pkg::xlen-1){1'b0}}, slt_bit};
        rv_exec_pkg::alu_sltu: alu_result1 = {{(rv_exec_pkg::xlen-1){1'b0}}, sltu_bit};
        rv_exec_pkg::alu_and:  alu_result1 = alu.src1 & alu.src2;
        rv_exec_pkg::alu_or:   alu_result1 = alu.src1 | alu.src2;
        rv_exec_pkg::alu_xor:  alu_result1 = alu.src1 ^ alu.src2;
        rv_exec_pkg::alu_lui:  alu_result1 = alu.src2;
        rv_exec_pkg::alu_sll:  alu_result1 = sll_value;
        rv_exec_pkg::alu_srl,
        rv_exec_pkg::alu_sra:  alu_result1 = sr64_value[rv_exec_pkg::xlen-1:0];
        default:               alu_result1 = adder_sum;
      endcase
    end
  end

  always_comb begin
    alu_result2 = '0;
    if (!alu.double_cal) begin
      alu_result2 = {{(rv_exec_pkg::xlen-1){1'b0}}, 1'b1};
    end else begin
      case (alu.alu_op)
        rv_exec_pkg::alu_beq:  alu_result2[0] = eq_bit;
        rv_exec_pkg::alu_bne:  alu_result2[0] = ~eq_bit;
        rv_exec_pkg::alu_blt:  alu_result2[0] = lt_bit;
        rv_exec_pkg::alu_bge:  alu_result2[0] = ~lt_bit;
        rv_exec_pkg::alu_bltu: alu_result2[0] = ltu_bit;
        rv_exec_pkg::alu_bgeu: alu_result2[0] = ~ltu_bit;
        default:               alu_result2[0] = 1'b0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/rv_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
  input  logic [rv_exec_pkg::xlen-1:0]       instr,
  input  logic [rv_exec_pkg::xlen-1:0]       pc,
  input  logic [rv_exec_pkg::xlen-1:0]       rs1_data,
  input  logic [rv_exec_pkg::xlen-1:0]       rs2_data,
  output logic [rv_exec_pkg::reg_addr_w-1:0] rs1_addr,
  output logic [rv_exec_pkg::reg_addr_w-1:0] rs2_addr,
  output logic [rv_exec_pkg::reg_addr_w-1:0] rd_addr,
  output logic                               rd_we,
  alu_req_if.decoder                         alu
);

  rv_exec_pkg::opcode_e         opcode;
  logic [2:0]                   funct3;
  logic                         alt;
  logic [rv_exec_pkg::xlen-1:0] imm_i;
  logic [rv_exec_pkg::xlen-1:0] imm_u;
  logic [rv_exec_pkg::xlen-1:0] imm_b;

  // OP and OP-IMM share this map, only the register form has sub
  function automatic rv_exec_pkg::alu_op_e arith_op(
    input logic [2:0] f3,
    input logic       alt7,
    input logic       reg_form
  );
    case (f3)
      rv_exec_pkg::f3_add:  return (alt7 && reg_form) ? rv_exec_pkg::alu_sub
                                                      : rv_exec_pkg::alu_add;
      rv_exec_pkg::f3_sll:  return rv_exec_pkg::alu_sll;
      rv_exec_pkg::f3_slt:  return rv_exec_pkg::alu_slt;
      rv_exec_pkg::f3_sltu: return rv_exec_pkg::alu_sltu;
      rv_exec_pkg::f3_xor:  return rv_exec_pkg::alu_xor;
      rv_exec_pkg::f3_sr:   return alt7 ? rv_exec_pkg::alu_sra : rv_exec_pkg::alu_srl;
      rv_exec_pkg::f3_or:   return rv_exec_pkg::alu_or;
      default:              return rv_exec_pkg::alu_and;
    endcase
  endfunction

  function automatic rv_exec_pkg::alu_op_e branch_op(input logic [2:0] f3);
    case (f3)
      rv_exec_pkg::f3_bne:  return rv_exec_pkg::alu_bne;
      rv_exec_pkg::f3_blt:  return rv_exec_pkg::alu_blt;
      rv_exec_pkg::f3_bge:  return rv_exec_pkg::alu_bge;
      rv_exec_pkg::f3_bltu: return rv_exec_pkg::alu_bltu;
      rv_exec_pkg::f3_bgeu: return rv_exec_pkg::alu_bgeu;
      default:              return rv_exec_pkg::alu_beq;  // f3_beq and the two reserved codes
    endcase
  endfunction

  // Fields --------------
  assign opcode   = rv_exec_pkg::opcode_e'(instr[6:0]);
  assign funct3   = instr[14:12];
  assign alt      = instr[30];  // funct7 bit 5
  assign rd_addr  = instr[11:7];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

  // Source steering ------
  always_comb begin
    alu.alu_op     = rv_exec_pkg::alu_add;
    alu.double_cal = 1'b0;
    alu.src1       = rs1_data;
    alu.src2       = rs2_data;
    alu.src3       = rs1_data;  // Only the branch compare looks at src3 and src4
    alu.src4       = rs2_data;
    rd_we          = 1'b0;
    case (opcode)
      rv_exec_pkg::op_reg: begin
        alu.alu_op = arith_op(funct3, alt, 1'b1);
        rd_we      = 1'b1;
      end
      rv_exec_pkg::op_imm: begin
        alu.alu_op = arith_op(funct3, alt, 1'b0);
        alu.src2   = imm_i;  // Shift amount sits in the low five bits
        rd_we      = 1'b1;
      end
      rv_exec_pkg::op_lui: begin
        alu.alu_op = rv_exec_pkg::alu_lui;
        alu.src2   = imm_u;
        rd_we      = 1'b1;
      end
      rv_exec_pkg::op_auipc: begin
        alu.src1 = pc;
        alu.src2 = imm_u;
        rd_we    = 1'b1;
      end
      rv_exec_pkg::op_branch: begin
        alu.alu_op     = branch_op(funct3);
        alu.double_cal = 1'b1;
        alu.src1       = pc;
        alu.src2       = imm_b;
      end
      default: begin
        rd_we = 1'b0;  // Unsupported opcode retires without a write
      end
    endcase
  end

endmodule

`default_nettype wire

/* rtl/rv_exec_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_exec_ctrl (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               req,
  output logic                               ack,
  alu_req_if.ctrl                            alu,
  input  logic [rv_exec_pkg::xlen-1:0]       alu_result1,
  input  logic [rv_exec_pkg::xlen-1:0]       alu_result2,
  input  logic [rv_exec_pkg::reg_addr_w-1:0] rd_addr,
  input  logic                               rd_we,
  output logic                               wr_en,
  output logic [rv_exec_pkg::reg_addr_w-1:0] wr_addr,
  output logic [rv_exec_pkg::xlen-1:0]       wr_data,
  output logic [rv_exec_pkg::xlen-1:0]       result,
  output logic                               branch_taken
);

  rv_exec_pkg::ctrl_state_e state;
  logic                     accept;

  // Accept happens on the single idle cycle that sees req
  assign accept  = (state == rv_exec_pkg::st_idle) && req;
  assign wr_en   = accept && rd_we;  // One write per transaction, even if req is held
  assign wr_addr = rd_addr;
  assign wr_data = alu_result1;
  assign ack     = (state == rv_exec_pkg::st_done);

  // Handshake FSM --------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= rv_exec_pkg::st_idle;
    end else begin
      case (state)
        rv_exec_pkg::st_idle: begin
          if (req) begin
            state <= rv_exec_pkg::st_done;
          end
        end
        rv_exec_pkg::st_done: begin
          if (!req) begin
            state <= rv_exec_pkg::st_idle;  // Ack drops on this edge
          end
        end
        default: begin
          state <= rv_exec_pkg::st_idle;
        end
      endcase
    end
  end

  // Results stay put until the next accept
  always_ff @(posedge clk) begin
    if (reset) begin
      result       <= '0;
      branch_taken <= 1'b0;
    end else if (accept) begin
      result       <= alu_result1;
      branch_taken <= alu.double_cal & alu_result2[0];
    end
  end

endmodule

`default_nettype wire

/* rtl/rv_exec_pkg.sv */
`default_nettype none

package rv_exec_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int reg_count  = 1 << reg_addr_w;

  // Major opcodes --------
  typedef enum logic [6:0] {
    op_reg    = 7'b0110011,
    op_imm    = 7'b0010011,
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_branch = 7'b1100011
  } opcode_e;

  // funct3 codes ---------
  localparam logic [2:0] f3_add  = 3'b000;  // Also sub in the register form
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;  // funct7 bit 5 picks sra
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // ALU operations -------
  typedef enum logic [4:0] {
    alu_add,
    alu_sub,
    alu_slt,
    alu_sltu,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_lui,
    alu_bne,
    alu_beq,
    alu_bge,
    alu_bgeu,
    alu_blt,
    alu_bltu
  } alu_op_e;

  typedef enum logic {
    st_idle,
    st_done
  } ctrl_state_e;

endpackage

`default_nettype wire

/* rtl/rv_exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_exec_top (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         req,
  output logic                         ack,
  input  logic [rv_exec_pkg::xlen-1:0] instr,
  input  logic [rv_exec_pkg::xlen-1:0] pc,
  output logic [rv_exec_pkg::xlen-1:0] result,
  output logic                         branch_taken
);

  logic [rv_exec_pkg::reg_addr_w-1:0] rs1_addr;
  logic [rv_exec_pkg::reg_addr_w-1:0] rs2_addr;
  logic [rv_exec_pkg::reg_addr_w-1:0] rd_addr;
  logic                               rd_we;
  logic [rv_exec_pkg::xlen-1:0]       rs1_data;
  logic [rv_exec_pkg::xlen-1:0]       rs2_data;
  logic [rv_exec_pkg::xlen-1:0]       alu_result1;
  logic [rv_exec_pkg::xlen-1:0]       alu_result2;
  logic                               wr_en;
  logic [rv_exec_pkg::reg_addr_w-1:0] wr_addr;
  logic [rv_exec_pkg::xlen-1:0]       wr_data;

  alu_req_if alu_bus ();

  // Combinational path --
  rv_decoder u_decoder (
    .instr    (instr),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .rd_we    (rd_we),
    .alu      (alu_bus.decoder)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .reset    (reset),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data)
  );

  rv_alu u_alu (
    .alu         (alu_bus.alu),
    .alu_result1 (alu_result1),
    .alu_result2 (alu_result2)
  );

  // Sequencing -----------
  rv_exec_ctrl u_ctrl (
    .clk          (clk),
    .reset        (reset),
    .req          (req),
    .ack          (ack),
    .alu          (alu_bus.ctrl),
    .alu_result1  (alu_result1),
    .alu_result2  (alu_result2),
    .rd_addr      (rd_addr),
    .rd_we        (rd_we),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .result       (result),
    .branch_taken (branch_taken)
  );

endmodule

`default_nettype wire

/* rtl/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [rv_exec_pkg::reg_addr_w-1:0] rs1_addr,
  input  logic [rv_exec_pkg::reg_addr_w-1:0] rs2_addr,
  output logic [rv_exec_pkg::xlen-1:0]       rs1_data,
  output logic [rv_exec_pkg::xlen-1:0]       rs2_data,
  input  logic                               wr_en,
  input  logic [rv_exec_pkg::reg_addr_w-1:0] wr_addr,
  input  logic [rv_exec_pkg::xlen-1:0]       wr_data
);

  // x0 has no storage
  logic [rv_exec_pkg::xlen-1:0] regs [1:rv_exec_pkg::reg_count-1];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < rv_exec_pkg::reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Reads see the value from before a same-cycle write
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the output for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -f project.f --top-module tb_rv_exec \
  --Mdir obj_dir -o tb_rv_exec &&
./obj_dir/tb_rv_exec | tee /dev/stderr | grep -q "No errors" &&
echo "PASS" || { echo "FAIL"; exit 1; }
